// File: commit_trace.f
+incdir+.
commit_trace_pkg.sv
writeback_if.sv
counter_if.sv
commit_capture.sv
trap_counters.sv
apb_regs.sv
commit_trace.sv
tb_commit_trace.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_commit_trace
FILELIST  = commit_trace.f
LOG       = sim.log

SOURCES = $(wildcard *.sv *.svh)
BIN     = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -F -q '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_commit_trace.sv
`timescale 1ns/1ns
`include "commit_trace_macros.svh"

module tb_commit_trace;

  // the tests take under 200 cycles, with generous margin
  localparam int max_cycles = 2000;

  logic                          clock = 1'b0;
  logic                          reset;
  logic                          wb_valid;
  commit_trace_pkg::pc_t         wb_pc;
  commit_trace_pkg::pc_t         wb_inst;
  logic                          wb_wen;
  commit_trace_pkg::rd_addr_t    wb_rd_addr;
  commit_trace_pkg::xlen_t       wb_rd_data;
  commit_trace_pkg::exit_code_t  exit_code;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  commit_trace_pkg::apb_addr_t   paddr;
  commit_trace_pkg::apb_data_t   pwdata;
  commit_trace_pkg::apb_data_t   prdata;
  logic                          pready;
  logic                          pslverr;
  logic                          commit_valid;
  commit_trace_pkg::pc_t         commit_pc;
  commit_trace_pkg::pc_t         commit_inst;
  logic                          commit_wen;
  commit_trace_pkg::wdest_t      commit_wdest;
  commit_trace_pkg::xlen_t       commit_wdata;
  logic                          commit_skip;
  logic                          trap_valid;
  commit_trace_pkg::exit_code_t  trap_code;

  integer seed;
  int     cycles = 0;
  string  test_name = "none";

  commit_trace uut (.*);

  always #4 clock = ~clock;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles >= max_cycles) begin
      report_error($sformatf("timeout: the tests did not finish within %0d cycles", max_cycles));
    end
  end

  task automatic check_record(input string what, input commit_trace_pkg::commit_rec_t expected,
                              input commit_trace_pkg::commit_rec_t actual);
    if (actual !== expected) begin
      report_error($sformatf("FAIL %s %s expected %h actual %h",
                             test_name, what, expected, actual));
    end
  endtask

  task automatic check_count(input string what, input commit_trace_pkg::count_t expected,
                             input commit_trace_pkg::count_t actual);
    if (actual !== expected) begin
      report_error($sformatf("FAIL %s %s expected %0d actual %0d",
                             test_name, what, expected, actual));
    end
  endtask

  task automatic check_apb(input string what, input commit_trace_pkg::apb_data_t expected,
                           input commit_trace_pkg::apb_data_t actual);
    if (actual !== expected) begin
      report_error($sformatf("FAIL %s %s expected %h actual %h",
                             test_name, what, expected, actual));
    end
  endtask

  task automatic check_code(input string what, input commit_trace_pkg::exit_code_t expected,
                            input commit_trace_pkg::exit_code_t actual);
    if (actual !== expected) begin
      report_error($sformatf("FAIL %s %s expected %h actual %h",
                             test_name, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_error($sformatf("FAIL %s %s expected %b actual %b",
                             test_name, what, expected, actual));
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  function automatic commit_trace_pkg::commit_rec_t random_event(input logic valid);
    commit_trace_pkg::commit_rec_t ev;
    logic [31:0]                   r;
    r        = $random(seed);
    ev.valid = valid;
    ev.pc    = $random(seed);
    ev.inst  = $random(seed);
    // keep random traffic away from the trap opcode
    if (ev.inst[6:0] == `TRAP_OPCODE) begin
      ev.inst[6] = 1'b0;
    end
    ev.wen   = r[8];
    ev.wdest = {3'b000, r[4:0]};
    ev.wdata = {$random(seed), $random(seed)};
    return ev;
  endfunction

  task automatic drive_event(input commit_trace_pkg::commit_rec_t ev);
    wb_valid   = ev.valid;
    wb_pc      = ev.pc;
    wb_inst    = ev.inst;
    wb_wen     = ev.wen;
    wb_rd_addr = ev.wdest[4:0];
    wb_rd_data = ev.wdata;
  endtask

  task automatic drive_idle();
    wb_valid   = 1'b0;
    wb_pc      = '0;
    wb_inst    = '0;
    wb_wen     = 1'b0;
    wb_rd_addr = '0;
    wb_rd_data = '0;
  endtask

  function automatic commit_trace_pkg::commit_rec_t observed();
    return {commit_valid, commit_pc, commit_inst, commit_wen, commit_wdest, commit_wdata};
  endfunction

  // outputs one cycle after the event went in
  task automatic check_outputs(input commit_trace_pkg::commit_rec_t ev);
    if (ev.valid) begin
      check_record("commit record", ev, observed());
    end else begin
      check_flag("commit_valid", 1'b0, commit_valid);
    end
    check_flag("commit_skip", ev.inst == `SKIP_INST, commit_skip);
  endtask

  task automatic apb_access(input logic write, input commit_trace_pkg::apb_addr_t addr,
                            input commit_trace_pkg::apb_data_t data,
                            output commit_trace_pkg::apb_data_t rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    #2;
    check_flag("pready", 1'b1, pready);
    rdata = prdata;
    err   = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input commit_trace_pkg::apb_addr_t addr,
                           input commit_trace_pkg::apb_data_t data, output logic err);
    commit_trace_pkg::apb_data_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input commit_trace_pkg::apb_addr_t addr,
                          output commit_trace_pkg::apb_data_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  task automatic read_count(input commit_trace_pkg::apb_addr_t lo_addr,
                            output commit_trace_pkg::count_t value);
    commit_trace_pkg::apb_data_t lo;
    commit_trace_pkg::apb_data_t hi;
    logic                        err;
    apb_read(lo_addr, lo, err);
    apb_read(lo_addr + 8'h04, hi, err);
    value = {hi, lo};
  endtask

  task automatic test_reset();
    commit_trace_pkg::apb_data_t data;
    logic                        err;
    test_name = "reset";
    check_flag("commit_valid", 1'b0, commit_valid);
    check_flag("commit_skip", 1'b0, commit_skip);
    check_flag("trap_valid", 1'b0, trap_valid);
    check_flag("pready", 1'b0, pready);
    check_flag("pslverr", 1'b0, pslverr);
    apb_read(`REG_CTRL, data, err);
    check_apb("ctrl", 32'h1, data);
    check_flag("ctrl pslverr", 1'b0, err);
  endtask

  task automatic test_capture();
    commit_trace_pkg::commit_rec_t prev;
    commit_trace_pkg::commit_rec_t cur;
    logic [31:0]                   r;
    test_name = "capture";
    prev = random_event(1'b1);
    drive_event(prev);
    for (int i = 0; i < 60; i++) begin
      r   = $random(seed);
      cur = random_event(r[1:0] != 2'b00);
      next_cycle();
      check_outputs(prev);
      drive_event(cur);
      prev = cur;
    end
    next_cycle();
    check_outputs(prev);
    drive_idle();
  endtask

  task automatic test_counts();
    commit_trace_pkg::count_t first;
    commit_trace_pkg::count_t second;
    logic [31:0]              r;
    int                       k;
    logic                     err;
    test_name = "counts";
    apb_write(`REG_CTRL, 32'h3, err);
    k = 0;
    for (int i = 0; i < 50; i++) begin
      r = $random(seed);
      if (r[0]) begin
        drive_event(random_event(1'b1));
        k++;
      end else begin
        drive_idle();
      end
      next_cycle();
    end
    drive_idle();
    read_count(`REG_INSTR_LO, first);
    check_count("retired instructions", k, first);
    // disabled unit must not count cycles
    apb_write(`REG_CTRL, 32'h0, err);
    read_count(`REG_CYCLE_LO, first);
    repeat (12) next_cycle();
    read_count(`REG_CYCLE_LO, second);
    check_count("cycle count while disabled", first, second);
    apb_write(`REG_CTRL, 32'h1, err);
  endtask

  task automatic test_skip();
    commit_trace_pkg::commit_rec_t ev;
    commit_trace_pkg::pc_t         insts[4];
    test_name = "skip";
    insts = '{`SKIP_INST, 32'h0000007c, 32'h0000017b, `SKIP_INST};
    for (int i = 0; i < 4; i++) begin
      ev      = random_event(1'b1);
      ev.inst = insts[i];
      drive_event(ev);
      next_cycle();
      drive_idle();
      check_outputs(ev);
    end
  endtask

  task automatic test_trap();
    commit_trace_pkg::commit_rec_t trap_ev;
    commit_trace_pkg::commit_rec_t frozen;
    commit_trace_pkg::commit_rec_t ev;
    commit_trace_pkg::exit_code_t  code;
    commit_trace_pkg::apb_data_t   data;
    commit_trace_pkg::count_t      count;
    logic [31:0]                   r;
    logic                          err;
    test_name = "trap";
    apb_write(`REG_CTRL, 32'h3, err);
    r                  = $random(seed);
    code               = r[7:0];
    trap_ev            = random_event(1'b1);
    trap_ev.inst[6:0]  = `TRAP_OPCODE;
    drive_event(trap_ev);
    exit_code = code;
    next_cycle();
    drive_idle();
    exit_code = ~code;
    check_flag("trap_valid", 1'b1, trap_valid);
    check_code("trap_code", code, trap_code);
    check_record("trapping commit", trap_ev, observed());
    apb_read(`REG_STATUS, data, err);
    check_apb("status", {16'h0, code, 7'h0, 1'b1}, data);
    frozen       = trap_ev;
    frozen.valid = 1'b0;
    for (int i = 0; i < 8; i++) begin
      ev = random_event(1'b1);
      // a second trap and a skip word must not get through either
      if (i == 2) begin
        ev.inst[6:0] = `TRAP_OPCODE;
      end
      if (i == 5) begin
        ev.inst = `SKIP_INST;
      end
      drive_event(ev);
      next_cycle();
      check_record("frozen commit", frozen, observed());
      check_code("frozen trap_code", code, trap_code);
      check_flag("frozen trap_valid", 1'b1, trap_valid);
      check_flag("frozen commit_skip", 1'b0, commit_skip);
    end
    drive_idle();
    read_count(`REG_INSTR_LO, count);
    check_count("instructions after trap", 1, count);
    // clear restarts capture
    apb_write(`REG_CTRL, 32'h3, err);
    check_flag("trap_valid after clear", 1'b0, trap_valid);
    ev = random_event(1'b1);
    drive_event(ev);
    next_cycle();
    drive_idle();
    check_outputs(ev);
  endtask

  task automatic test_slave_error();
    commit_trace_pkg::apb_data_t data;
    logic                        err;
    test_name = "slave error";
    apb_read(8'h40, data, err);
    check_flag("unmapped read pslverr", 1'b1, err);
    apb_write(`REG_STATUS, 32'h1, err);
    check_flag("status write pslverr", 1'b1, err);
    apb_read(`REG_LAST_PC, data, err);
    check_flag("mapped read pslverr", 1'b0, err);
  endtask

  initial begin
    seed      = 32'h134ffa35;
    reset     = 1'b1;
    exit_code = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    drive_idle();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    test_reset();
    test_capture();
    test_counts();
    test_skip();
    test_trap();
    test_slave_error();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: commit_trace.sv
`timescale 1ns/1ns

module commit_trace (
  input  logic                          clock,
  input  logic                          reset,
  // core write-back
  input  logic                          wb_valid,
  input  commit_trace_pkg::pc_t         wb_pc,
  input  commit_trace_pkg::pc_t         wb_inst,
  input  logic                          wb_wen,
  input  commit_trace_pkg::rd_addr_t    wb_rd_addr,
  input  commit_trace_pkg::xlen_t       wb_rd_data,
  input  commit_trace_pkg::exit_code_t  exit_code,
  // apb slave
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  commit_trace_pkg::apb_addr_t   paddr,
  input  commit_trace_pkg::apb_data_t   pwdata,
  output commit_trace_pkg::apb_data_t   prdata,
  output logic                          pready,
  output logic                          pslverr,
  // commit and trap outputs
  output logic                          commit_valid,
  output commit_trace_pkg::pc_t         commit_pc,
  output commit_trace_pkg::pc_t         commit_inst,
  output logic                          commit_wen,
  output commit_trace_pkg::wdest_t      commit_wdest,
  output commit_trace_pkg::xlen_t       commit_wdata,
  output logic                          commit_skip,
  output logic                          trap_valid,
  output commit_trace_pkg::exit_code_t  trap_code
);

  writeback_if wb_bus ();
  counter_if   cnt_bus ();

  logic                          enable;
  logic                          clear_pulse;
  logic                          halted;
  commit_trace_pkg::commit_rec_t last_rec;

  assign wb_bus.valid   = wb_valid;
  assign wb_bus.pc      = wb_pc;
  assign wb_bus.inst    = wb_inst;
  assign wb_bus.wen     = wb_wen;
  assign wb_bus.rd_addr = wb_rd_addr;
  assign wb_bus.rd_data = wb_rd_data;

  commit_capture u_capture (
    .clock       (clock),
    .reset       (reset),
    .wb          (wb_bus.capture),
    .halted      (halted),
    .clear_pulse (clear_pulse),
    .record      (last_rec),
    .skip        (commit_skip)
  );

  trap_counters u_counters (
    .clock       (clock),
    .reset       (reset),
    .wb          (wb_bus.monitor),
    .exit_code   (exit_code),
    .enable      (enable),
    .clear_pulse (clear_pulse),
    .halted      (halted),
    .cnt         (cnt_bus.counters)
  );

  apb_regs u_regs (
    .clock       (clock),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .cnt         (cnt_bus.regs),
    .last        (last_rec),
    .enable      (enable),
    .clear_pulse (clear_pulse)
  );

  assign commit_valid = last_rec.valid;
  assign commit_pc    = last_rec.pc;
  assign commit_inst  = last_rec.inst;
  assign commit_wen   = last_rec.wen;
  assign commit_wdest = last_rec.wdest;
  assign commit_wdata = last_rec.wdata;
  assign trap_valid   = cnt_bus.trapped;
  assign trap_code    = cnt_bus.exit_code;

endmodule

// File: apb_regs.sv
`timescale 1ns/1ns
`include "commit_trace_macros.svh"

module apb_regs (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  commit_trace_pkg::apb_addr_t   paddr,
  input  commit_trace_pkg::apb_data_t   pwdata,
  output commit_trace_pkg::apb_data_t   prdata,
  output logic                          pready,
  output logic                          pslverr,
  counter_if.regs                       cnt,
  input  commit_trace_pkg::commit_rec_t last,
  output logic                          enable,
  output logic                          clear_pulse
);

  logic                        access;
  logic                        wr_ctrl;
  logic                        mapped;
  commit_trace_pkg::apb_data_t rd_data;

  // zero wait, access phase is the whole transfer
  assign access  = psel && penable;
  assign pready  = access;
  assign wr_ctrl = access && pwrite && (paddr == `REG_CTRL);

  // clear acts at the same edge as the write
  assign clear_pulse = wr_ctrl && pwdata[1];

  always_ff @(posedge clock) begin
    if (reset) begin
      enable <= 1'b1;
    end else if (wr_ctrl) begin
      enable <= pwdata[0];
    end
  end

  // read decode
  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (paddr)
      `REG_CTRL:      rd_data = {31'b0, enable};
      `REG_STATUS:    rd_data = {16'b0, cnt.exit_code, 7'b0, cnt.trapped};
      `REG_CYCLE_LO:  rd_data = cnt.cycle_count[31:0];
      `REG_CYCLE_HI:  rd_data = cnt.cycle_count[63:32];
      `REG_INSTR_LO:  rd_data = cnt.instr_count[31:0];
      `REG_INSTR_HI:  rd_data = cnt.instr_count[63:32];
      `REG_LAST_PC:   rd_data = last.pc;
      `REG_LAST_INST: rd_data = last.inst;
      default:        mapped  = 1'b0;
    endcase
  end

  assign prdata = (access && !pwrite) ? rd_data : '0;

  // only the control register is writable
  assign pslverr = access && (!mapped || (pwrite && (paddr != `REG_CTRL)));

endmodule

// File: trap_counters.sv
`timescale 1ns/1ns
`include "commit_trace_macros.svh"

module trap_counters (
  input  logic                         clock,
  input  logic                         reset,
  writeback_if.monitor                 wb,
  input  commit_trace_pkg::exit_code_t exit_code,
  input  logic                         enable,
  input  logic                         clear_pulse,
  output logic                         halted,
  counter_if.counters                  cnt
);

  logic                         trapped;
  logic                         trap_hit;
  commit_trace_pkg::exit_code_t exit_q;
  commit_trace_pkg::count_t     cycle_q;
  commit_trace_pkg::count_t     instr_q;

  // everything freezes after the trap or when software disables the unit
  assign halted = trapped || !enable;

  assign trap_hit = wb.valid && (wb.inst[6:0] == `TRAP_OPCODE);

  always_ff @(posedge clock) begin
    if (reset || clear_pulse) begin
      trapped <= 1'b0;
      exit_q  <= '0;
      cycle_q <= '0;
      instr_q <= '0;
    end else if (!halted) begin
      cycle_q <= cycle_q + 1'b1;
      // the trapping instruction still counts as retired
      if (wb.valid) begin
        instr_q <= instr_q + 1'b1;
      end
      if (trap_hit) begin
        trapped <= 1'b1;
        exit_q  <= exit_code;
      end
    end
  end

  assign cnt.trapped     = trapped;
  assign cnt.exit_code   = exit_q;
  assign cnt.cycle_count = cycle_q;
  assign cnt.instr_count = instr_q;

endmodule

// File: commit_capture.sv
`timescale 1ns/1ns
`include "commit_trace_macros.svh"

module commit_capture (
  input  logic                          clock,
  input  logic                          reset,
  writeback_if.capture                  wb,
  input  logic                          halted,
  input  logic                          clear_pulse,
  output commit_trace_pkg::commit_rec_t record,
  output logic                          skip
);

  commit_trace_pkg::commit_rec_t next_rec;
  logic                          is_skip;

  // pack the incoming event
  always_comb begin
    next_rec.valid = wb.valid;
    next_rec.pc    = wb.pc;
    next_rec.inst  = wb.inst;
    next_rec.wen   = wb.wen;
    // zero extend the register address
    next_rec.wdest = commit_trace_pkg::wdest_t'(wb.rd_addr);
    next_rec.wdata = wb.rd_data;
  end

  // simulator skip word, compared on the raw instruction
  assign is_skip = (wb.inst == `SKIP_INST);

  always_ff @(posedge clock) begin
    if (reset || clear_pulse) begin
      record <= '0;
      skip   <= 1'b0;
    end else if (halted) begin
      // hold the last commit, but nothing retires
      record.valid <= 1'b0;
    end else begin
      record <= next_rec;
      skip   <= is_skip;
    end
  end

endmodule

// File: counter_if.sv
`timescale 1ns/1ns

// trap state and counters toward the register block
interface counter_if;

  logic                         trapped;
  commit_trace_pkg::exit_code_t exit_code;
  commit_trace_pkg::count_t     cycle_count;
  commit_trace_pkg::count_t     instr_count;

  modport counters (
    output trapped,
    output exit_code,
    output cycle_count,
    output instr_count
  );

  modport regs (
    input trapped,
    input exit_code,
    input cycle_count,
    input instr_count
  );

endinterface

// File: writeback_if.sv
`timescale 1ns/1ns

// one write-back event per cycle, valid marks the cycle
interface writeback_if;

  logic                       valid;
  commit_trace_pkg::pc_t      pc;
  commit_trace_pkg::pc_t      inst;
  logic                       wen;
  commit_trace_pkg::rd_addr_t rd_addr;
  commit_trace_pkg::xlen_t    rd_data;

  // core side
  modport source (output valid, pc, inst, wen, rd_addr, rd_data);

  // commit record builder
  modport capture (input valid, pc, inst, wen, rd_addr, rd_data);

  // trap detection only looks at the opcode
  modport monitor (input valid, inst);

endinterface

// File: commit_trace_pkg.sv
`include "commit_trace_macros.svh"

package commit_trace_pkg;

  // architectural register data
  typedef logic [`XLEN-1:0] xlen_t;

  // pc and raw instruction word share a width
  typedef logic [`PC_W-1:0] pc_t;

  typedef logic [`RD_W-1:0] rd_addr_t;

  // commit destination, wider than the register address
  typedef logic [`WDEST_W-1:0] wdest_t;

  // low byte of a0 at the trap
  typedef logic [7:0] exit_code_t;

  // cycle and retired instruction counters
  typedef logic [`XLEN-1:0] count_t;

  typedef logic [`APB_AW-1:0] apb_addr_t;
  typedef logic [`APB_DW-1:0] apb_data_t;

  // one committed instruction as seen by the checker
  typedef struct packed {
    logic   valid;
    pc_t    pc;
    pc_t    inst;
    logic   wen;
    wdest_t wdest;
    xlen_t  wdata;
  } commit_rec_t;

endpackage

// File: commit_trace_macros.svh
`ifndef COMMIT_TRACE_MACROS_SVH
`define COMMIT_TRACE_MACROS_SVH

// datapath widths
`define XLEN     64
`define PC_W     32
`define RD_W     5
`define WDEST_W  8

// special instruction encodings
`define TRAP_OPCODE 7'h6b
`define SKIP_INST   32'h7b

// apb bus
`define APB_AW 8
`define APB_DW 32

// register map
`define REG_CTRL      8'h00
`define REG_STATUS    8'h04
`define REG_CYCLE_LO  8'h08
`define REG_CYCLE_HI  8'h0c
`define REG_INSTR_LO  8'h10
`define REG_INSTR_HI  8'h14
`define REG_LAST_PC   8'h18
`define REG_LAST_INST 8'h1c

`endif
